// File: mem_subsys.f
rtl/mem_pkg.sv
rtl/agu.sv
rtl/access_timer.sv
rtl/data_ram.sv
rtl/dcache_ctrl.sv
rtl/mem_stage.sv
rtl/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// File: rtl/access_timer.sv
`timescale 1ns/1ns
`default_nettype none

module access_timer import mem_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);

    logic [TIMER_W-1:0] count;
    logic               armed;     // set by the first start after reset

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            armed <= 1'b0;
        end else if (start) begin
            count <= TIMER_W'(ACCESS_LAT);
            armed <= 1'b1;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // held until the next start reloads the counter
    assign done = armed && (count == '0);

endmodule

`default_nettype wire

// File: rtl/agu.sv
`timescale 1ns/1ns
`default_nettype none

module agu import mem_pkg::*; (
    input  logic [31:0] addr,
    input  logic [3:0]  width,
    input  logic        is_unsigned,
    input  logic [31:0] wdata,
    output agu_out_t    info,
    input  logic [1:0]  load_addr_lo,
    input  logic [3:0]  load_width,
    input  logic        load_unsigned,
    input  logic [31:0] rdata,
    output logic [31:0] load_result
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic        sext_b;
    logic        sext_h;

    // store side strobes, lane replication and alignment check
    always_comb begin
        info = '0;
        case (width)
            WIDTH_B: begin
                info.wstrb = 4'b0001 << addr[1:0];
                info.wdata = {4{wdata[7:0]}};
            end
            WIDTH_H: begin
                info.wstrb    = addr[1] ? 4'b1100 : 4'b0011;
                info.wdata    = {2{wdata[15:0]}};
                info.misalign = addr[0];
            end
            WIDTH_W: begin
                info.wstrb    = 4'b1111;
                info.wdata    = wdata;
                info.misalign = (addr[1:0] != 2'b00);
            end
            default: begin
                info = '0;              // no request selected
            end
        endcase

        // a zero width means the lanes are idle
        if (width != 4'd0) begin
            a_width_legal: assert (width == WIDTH_B || width == WIDTH_H || width == WIDTH_W)
                else $error("agu: illegal access width %0d", width);
        end
    end

    // load side
    assign load_byte = rdata[8*load_addr_lo +: 8];
    assign load_half = load_addr_lo[1] ? rdata[31:16] : rdata[15:0];
    assign sext_b    = ~load_unsigned & load_byte[7];
    assign sext_h    = ~load_unsigned & load_half[15];

    always_comb begin
        case (load_width)
            WIDTH_B: load_result = {{24{sext_b}}, load_byte};
            WIDTH_H: load_result = {{16{sext_h}}, load_half};
            default: load_result = rdata;       // whole word
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram import mem_pkg::*; (
    input  logic        clk,
    input  dram_req_t   dram_req,
    output logic [31:0] rdata
);

    logic [31:0] mem [RAM_WORDS];

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the word as it was before this cycle's write
    always @(posedge clk) begin
        if (dram_req.en) begin
            for (int b = 0; b < 4; b++) begin
                if (dram_req.wstrb[b]) begin
                    mem[dram_req.word_addr][8*b +: 8] <= dram_req.wdata[8*b +: 8];
                end
            end
            rdata <= mem[dram_req.word_addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  logic        req_we,
    input  logic [31:0] req_addr,
    input  agu_out_t    agu_info,
    output logic        start,
    input  logic        done,
    output dram_req_t   dram_req,
    input  logic [31:0] dram_rdata,
    output logic        ok,
    output logic [31:0] rdata
);

    ctrl_state_t            state;
    logic                   dram_en;
    logic [3:0]             wstrb_q;
    logic [WORD_ADDR_W-1:0] word_addr_q;
    logic [31:0]            wdata_q;
    logic [31:0]            rdata_q;

    assign start = (state == IDLE) && req_valid;
    assign ok    = (state == DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            dram_en <= 1'b0;
        end else begin
            dram_en <= start;       // one ram access per request
            case (state)
                IDLE:    if (req_valid) state <= ACCESS;
                ACCESS:  if (done) state <= DONE;
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            // loads and misaligned stores leave memory alone
            wstrb_q     <= (req_we && !agu_info.misalign) ? agu_info.wstrb : 4'b0000;
            word_addr_q <= req_addr[WORD_ADDR_W+1:2];
            wdata_q     <= agu_info.wdata;
        end
        if (state == ACCESS && done) begin
            rdata_q <= dram_rdata;
        end
    end

    assign dram_req = '{en: dram_en, wstrb: wstrb_q, word_addr: word_addr_q, wdata: wdata_q};
    assign rdata    = rdata_q;

    // timer and fsm together give a fixed start-to-ok distance
    a_ok_pulse: assert property (@(posedge clk) disable iff (rst)
        start |-> ##(ACCESS_LAT + 2) ok ##1 !ok)
        else $error("dcache_ctrl: ok not a single pulse at the expected cycle");

    // no new start until the access in flight is back in IDLE
    a_start_once: assert property (@(posedge clk) disable iff (rst)
        start |=> !start [*(ACCESS_LAT + 2)])
        else $error("dcache_ctrl: start outside IDLE");

endmodule

`default_nettype wire

// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // access width codes, given as a byte count
    localparam logic [3:0] WIDTH_B = 4'd1;
    localparam logic [3:0] WIDTH_H = 4'd2;
    localparam logic [3:0] WIDTH_W = 4'd4;

    localparam int WORD_ADDR_W = 8;                    // 256 words of data ram
    localparam int RAM_WORDS   = 1 << WORD_ADDR_W;
    localparam int ACCESS_LAT  = 3;                    // cycles per ram access
    localparam int TIMER_W     = $clog2(ACCESS_LAT + 1);

    // one memory op from an execute lane
    typedef struct packed {
        logic [31:0] addr;
        logic        is_unsigned;
        logic        we;
        logic        rd;
        logic [3:0]  width;
        logic [31:0] wdata;
        logic [31:0] pc;
    } ex_mem_req_t;

    // back to the execute stage
    typedef struct packed {
        logic        ok;          // one-cycle completion strobe
        logic        misalign;
        logic [31:0] result;
        logic [31:0] pc;
    } ms_resp_t;

    typedef struct packed {
        logic                   en;
        logic [3:0]             wstrb;
        logic [WORD_ADDR_W-1:0] word_addr;
        logic [31:0]            wdata;
    } dram_req_t;

    typedef struct packed {
        logic [3:0]  wstrb;
        logic [31:0] wdata;       // replicated into every byte lane
        logic        misalign;
    } agu_out_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ex_mem_req_t ex_req1,
    input  ex_mem_req_t ex_req2,
    output ms_resp_t    ms_resp,
    output logic        req_valid,
    output logic        req_we,
    output logic [31:0] req_addr,
    output agu_out_t    agu_info,
    input  logic        ok,
    input  logic [31:0] rdata
);

    ex_mem_req_t sel;
    logic [31:0] load_result;

    // winning op, kept for the response path
    logic [31:0] pc_q;
    logic [3:0]  width_q;
    logic        unsigned_q;
    logic [1:0]  addr_lo_q;
    logic        misalign_q;

    // fixed priority, lane 1 first
    always_comb begin
        if (ex_req1.we || ex_req1.rd) begin
            sel = ex_req1;
        end else if (ex_req2.we || ex_req2.rd) begin
            sel = ex_req2;
        end else begin
            sel = '0;
        end
    end

    assign req_valid = sel.we | sel.rd;
    assign req_we    = sel.we;
    assign req_addr  = sel.addr;

    agu i_agu (
        .addr          (sel.addr),
        .width         (sel.width),
        .is_unsigned   (sel.is_unsigned),
        .wdata         (sel.wdata),
        .info          (agu_info),
        .load_addr_lo  (addr_lo_q),
        .load_width    (width_q),
        .load_unsigned (unsigned_q),
        .rdata         (rdata),
        .load_result   (load_result)
    );

    // request is held by the driver until ok, so follow it up to then
    always_ff @(posedge clk) begin
        if (req_valid && !ok) begin
            pc_q       <= sel.pc;
            width_q    <= sel.width;
            unsigned_q <= sel.is_unsigned;
            addr_lo_q  <= sel.addr[1:0];
            misalign_q <= agu_info.misalign;
        end
    end

    assign ms_resp = '{ok: ok, misalign: misalign_q, result: load_result, pc: pc_q};

    a_no_rd_and_we: assert property (@(posedge clk) disable iff (rst)
        !(sel.we && sel.rd))
        else $error("mem_stage: selected op is both load and store");

endmodule

`default_nettype wire

// File: rtl/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ex_mem_req_t ex_req1,
    input  ex_mem_req_t ex_req2,
    output ms_resp_t    ms_resp
);

    logic        req_valid;
    logic        req_we;
    logic [31:0] req_addr;
    agu_out_t    agu_info;
    logic        ok;
    logic [31:0] rdata;
    logic        start;
    logic        done;
    dram_req_t   dram_req;
    logic [31:0] dram_rdata;

    mem_stage i_mem_stage (
        .clk       (clk),
        .rst       (rst),
        .ex_req1   (ex_req1),
        .ex_req2   (ex_req2),
        .ms_resp   (ms_resp),
        .req_valid (req_valid),
        .req_we    (req_we),
        .req_addr  (req_addr),
        .agu_info  (agu_info),
        .ok        (ok),
        .rdata     (rdata)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_we     (req_we),
        .req_addr   (req_addr),
        .agu_info   (agu_info),
        .start      (start),
        .done       (done),
        .dram_req   (dram_req),
        .dram_rdata (dram_rdata),
        .ok         (ok),
        .rdata      (rdata)
    );

    access_timer i_access_timer (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .done  (done)
    );

    data_ram i_data_ram (
        .clk      (clk),
        .dram_req (dram_req),
        .rdata    (dram_rdata)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f mem_subsys.f --top-module tb_mem_subsys -o sim_mem_subsys > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/sim_mem_subsys > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$SIM_LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0

// File: tests/tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    localparam int OK_TIMEOUT = 50;     // cycles allowed per op
    localparam int RAND_OPS   = 40;

    typedef struct packed {
        ex_mem_req_t req1;
        ex_mem_req_t req2;
        logic        chk_res;           // result only compared for loads
        logic [31:0] exp_result;
        logic        exp_misalign;
        logic        exp_lane2;         // pc expected from lane 2
    } entry_t;

    logic        clk;
    logic        rst;
    ex_mem_req_t ex_req1;
    ex_mem_req_t ex_req2;
    ms_resp_t    ms_resp;

    entry_t      table_q[$];
    logic [7:0]  shadow [1024];         // byte image of the ram, low 10 address bits
    integer      seed;
    int          errors;
    int          timeouts;
    int          checks;
    bit          aborted;

    mem_subsys_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .ex_req1 (ex_req1),
        .ex_req2 (ex_req2),
        .ms_resp (ms_resp)
    );

    always #2 clk = ~clk;

    function automatic ex_mem_req_t make_req(input logic we, input logic [3:0] width,
                                             input logic uns, input logic [31:0] addr,
                                             input logic [31:0] wdata, input logic [31:0] pc);
        ex_mem_req_t r;
        r             = '0;
        r.addr        = addr;
        r.is_unsigned = uns;
        r.we          = we;
        r.rd          = !we;
        r.width       = width;
        r.wdata       = wdata;
        r.pc          = pc;
        return r;
    endfunction

    task automatic add_entry(input ex_mem_req_t req1, input ex_mem_req_t req2,
                             input logic chk_res, input logic [31:0] exp_result,
                             input logic exp_misalign, input logic exp_lane2);
        entry_t e;
        e.req1         = req1;
        e.req2         = req2;
        e.chk_res      = chk_res;
        e.exp_result   = exp_result;
        e.exp_misalign = exp_misalign;
        e.exp_lane2    = exp_lane2;
        table_q.push_back(e);
    endtask

    function automatic logic is_misaligned(input ex_mem_req_t r);
        return (r.width == WIDTH_H && r.addr[0]) ||
               (r.width == WIDTH_W && r.addr[1:0] != 2'b00);
    endfunction

    // little endian, byte i of the store data goes to address + i
    task automatic store_shadow(input ex_mem_req_t r);
        logic [9:0] idx;
        int         n;
        n = int'(r.width);
        if (!is_misaligned(r)) begin
            for (int i = 0; i < n; i++) begin
                idx         = r.addr[9:0] + 10'(i);
                shadow[idx] = r.wdata[8*i +: 8];
            end
        end
    endtask

    function automatic logic [31:0] load_shadow(input ex_mem_req_t r);
        logic [31:0] v;
        logic [9:0]  idx;
        int          n;
        v = '0;
        n = int'(r.width);
        for (int i = 0; i < n; i++) begin
            idx          = r.addr[9:0] + 10'(i);
            v[8*i +: 8]  = shadow[idx];
        end
        if (!r.is_unsigned && r.width == WIDTH_B && v[7]) v[31:8] = '1;
        if (!r.is_unsigned && r.width == WIDTH_H && v[15]) v[31:16] = '1;
        return v;
    endfunction

    task automatic check_result(input ms_resp_t got, input logic [31:0] exp, input string what);
        checks++;
        if (got.result !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s result %h, expected %h", $time, what, got.result, exp);
        end
    endtask

    task automatic check_flag(input ms_resp_t got, input logic exp, input string what);
        checks++;
        if (got.misalign !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s misalign %b, expected %b", $time, what, got.misalign, exp);
        end
    endtask

    task automatic check_pc(input ms_resp_t got, input logic [31:0] exp, input string what);
        checks++;
        if (got.pc !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s pc %h, expected %h", $time, what, got.pc, exp);
        end
    endtask

    // lanes held until ok is seen, released at the following edge
    task automatic run_op(input ex_mem_req_t req1, input ex_mem_req_t req2,
                          output ms_resp_t resp, output bit seen);
        int waited;
        seen    = 1'b0;
        waited  = 0;
        ex_req1 = req1;
        ex_req2 = req2;
        while (!seen && waited < OK_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
            seen = ms_resp.ok;
        end
        resp = ms_resp;
        if (!seen) begin
            $display("timeout at %0t: ok never arrived within %0d cycles", $time, OK_TIMEOUT);
            timeouts++;
            aborted = 1'b1;
        end
        @(posedge clk);
        #1;
        ex_req1 = '0;
        ex_req2 = '0;
    endtask

    task automatic build_table();
        ex_mem_req_t idle;
        idle = '0;
        add_entry(make_req(1, WIDTH_W, 0, 32'h100, 32'h12345678, 32'h1000), idle, 0, 0, 0, 0);
        add_entry(make_req(0, WIDTH_W, 0, 32'h100, 0, 32'h1004), idle, 1, 32'h12345678, 0, 0);
        add_entry(make_req(1, WIDTH_B, 0, 32'h101, 32'h000000ab, 32'h1008), idle, 0, 0, 0, 0);
        add_entry(make_req(1, WIDTH_H, 0, 32'h102, 32'h00009abc, 32'h100c), idle, 0, 0, 0, 0);
        add_entry(make_req(0, WIDTH_W, 0, 32'h100, 0, 32'h1010), idle, 1, 32'h9abcab78, 0, 0);
        add_entry(make_req(0, WIDTH_B, 0, 32'h101, 0, 32'h1014), idle, 1, 32'hffffffab, 0, 0);
        add_entry(make_req(0, WIDTH_B, 1, 32'h101, 0, 32'h1018), idle, 1, 32'h000000ab, 0, 0);
        add_entry(make_req(0, WIDTH_H, 0, 32'h102, 0, 32'h101c), idle, 1, 32'hffff9abc, 0, 0);
        add_entry(make_req(0, WIDTH_H, 1, 32'h102, 0, 32'h1020), idle, 1, 32'h00009abc, 0, 0);
        add_entry(make_req(0, WIDTH_B, 0, 32'h100, 0, 32'h1024), idle, 1, 32'h00000078, 0, 0);
        // both lanes busy, lane 2 must not reach memory
        add_entry(make_req(1, WIDTH_W, 0, 32'h200, 32'h0badf00d, 32'h2000),
                  make_req(1, WIDTH_W, 0, 32'h204, 32'hdeadbeef, 32'h2100), 0, 0, 0, 0);
        add_entry(make_req(0, WIDTH_W, 0, 32'h204, 0, 32'h2004),
                  make_req(0, WIDTH_W, 0, 32'h200, 0, 32'h2104), 1, 32'h00000000, 0, 0);
        add_entry(idle, make_req(0, WIDTH_W, 0, 32'h200, 0, 32'h2200), 1, 32'h0badf00d, 0, 1);
        add_entry(idle, make_req(1, WIDTH_H, 0, 32'h206, 32'h0000cafe, 32'h2204), 0, 0, 0, 1);
        add_entry(idle, make_req(0, WIDTH_W, 0, 32'h204, 0, 32'h2208), 1, 32'hcafe0000, 0, 1);
        // misaligned stores complete but leave the word alone
        add_entry(make_req(1, WIDTH_H, 0, 32'h103, 32'h00001111, 32'h3000), idle, 0, 0, 1, 0);
        add_entry(make_req(1, WIDTH_W, 0, 32'h102, 32'h22222222, 32'h3004), idle, 0, 0, 1, 0);
        add_entry(make_req(0, WIDTH_W, 0, 32'h100, 0, 32'h3008), idle, 1, 32'h9abcab78, 0, 0);
    endtask

    initial begin
        ms_resp_t    resp;
        ex_mem_req_t sel;
        ex_mem_req_t op;
        ex_mem_req_t idle;
        bit          seen;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] addr;
        logic [3:0]  width;
        string       what;

        clk      = 1'b0;
        rst      = 1'b1;
        ex_req1  = '0;
        ex_req2  = '0;
        idle     = '0;
        seed     = 32'hf59e;
        errors   = 0;
        timeouts = 0;
        checks   = 0;
        aborted  = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            shadow[10'(i)] = '0;
        end
        build_table();

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int k = 0; k < table_q.size() && !aborted; k++) begin
            what = $sformatf("table entry %0d", k);
            run_op(table_q[k].req1, table_q[k].req2, resp, seen);
            if (seen) begin
                sel = table_q[k].exp_lane2 ? table_q[k].req2 : table_q[k].req1;
                if (table_q[k].chk_res) check_result(resp, table_q[k].exp_result, what);
                check_flag(resp, table_q[k].exp_misalign, what);
                check_pc(resp, sel.pc, what);
                if (sel.we) store_shadow(sel);
            end
        end

        // random aligned ops in a small window so loads hit earlier stores
        for (int i = 0; i < RAND_OPS && !aborted; i++) begin
            what  = $sformatf("random op %0d", i);
            r     = $random(seed);
            a     = $random(seed);
            d     = $random(seed);
            width = (r[2:1] == 2'd0) ? WIDTH_B : (r[2:1] == 2'd1) ? WIDTH_H : WIDTH_W;
            addr  = 32'h300 | {26'd0, a[5:0]};
            if (width == WIDTH_H) addr[0] = 1'b0;
            if (width == WIDTH_W) addr[1:0] = 2'b00;
            op = make_req(r[0], width, r[3], addr, d, 32'h4000 + 32'(4 * i));
            if (r[4]) run_op(idle, op, resp, seen);
            else run_op(op, idle, resp, seen);
            if (seen) begin
                if (!op.we) check_result(resp, load_shadow(op), what);
                check_flag(resp, 1'b0, what);
                check_pc(resp, op.pc, what);
                if (op.we) store_shadow(op);
            end
        end

        $display("checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
